//--- compile.f
+incdir+verilog
verilog/mmioPkg.sv
verilog/ioController.sv
verilog/inputPort.sv
verilog/intervalTimer.sv
verilog/displayPorts.sv
verilog/ioSubsystem.sv
verif/ioSubsystem_checker.sv
verif/ioSubsystem_tb.sv

//--- verif/ioSubsystem_checker.sv
`timescale 1ns/1ps

module ioSubsystem_checker
  import mmioPkg::*;
(
  input logic      clk,
  input logic      reset,
  input busReq_t   busReq,
  input word_t     rdata,
  input ledVec_t   ledr,
  input hexSegs_t  hex,
  input logic      irq,
  input irqCause_t irqCause
);

  // assertion failures so far
  int unsigned failCount = 0;

  // request line and cause code agree
  irqMatchesCause: assert property (
    @(posedge clk) disable iff (reset) irq == (irqCause != 2'd0)
  ) else begin
    failCount++;
    $error("irq and irqCause disagree");
  end

  // idle read port returns zero
  rdataIdleZero: assert property (
    @(posedge clk) disable iff (reset) !busReq.rdStb |-> rdata == '0
  ) else begin
    failCount++;
    $error("rdata nonzero without a read strobe");
  end

  // outputs only move after a write
  displayHolds: assert property (
    @(posedge clk) disable iff (reset) !busReq.wrStb |=> $stable(ledr) && $stable(hex)
  ) else begin
    failCount++;
    $error("ledr or hex changed without a write");
  end

endmodule

bind ioSubsystem ioSubsystem_checker checkerInst (.*);

//--- verif/ioSubsystem_tb.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module ioSubsystem_tb
  import mmioPkg::*;
();

  // short periods so the run stays small
  localparam int KEY_SAMPLE   = 4;
  localparam int SW_SAMPLE    = 4;
  localparam int TICK         = 3;
  localparam int RESET_CYCLES = 10;
  localparam int MARGIN       = 50;
  // stable level is latched within three sample periods
  localparam int SETTLE_WAIT  = 3 * KEY_SAMPLE + 2;
  localparam int INPUT_BUDGET = 4 * KEY_SAMPLE;
  // limit 2 times tick plus two cycles
  localparam int TIMER_BUDGET = 2 * TICK + 2;

  localparam word_t HEX_ADDR  = `ADDR_HEX;
  localparam word_t LED_ADDR  = `ADDR_LEDR;
  localparam word_t KEY_DATA  = `ADDR_KEY;
  localparam word_t KEY_CTRL  = `ADDR_KEY + `CTRL_OFFSET;
  localparam word_t SW_DATA   = `ADDR_SW;
  localparam word_t SW_CTRL   = `ADDR_SW + `CTRL_OFFSET;
  localparam word_t TMR_COUNT = `ADDR_TIMER;
  localparam word_t TMR_LIMIT = `ADDR_TIMER + `LIMIT_OFFSET;
  localparam word_t TMR_CTRL  = `ADDR_TIMER + `TCTRL_OFFSET;
  localparam word_t IE_BIT    = 32'h1 << `CTRL_IE;

  // active-low digit shapes, gfedcba, worked out per digit
  localparam hexSegs_t SEGS_FEDEAD = 42'b0001110_0000110_0100001_0000110_0001000_0100001;
  localparam hexSegs_t SEGS_123ABC = 42'b1111001_0100100_0110000_0001000_0000011_1000110;

  typedef enum logic [3:0] {
    actWrite, actRead, actKeys, actSwitches, actWait,
    actWaitCause, actCheckIrq, actCheckLed, actCheckHex, actEnd
  } action_t;

  // data is the tolerance for reads and the cycle budget for waits
  typedef struct {
    action_t     act;
    word_t       addr;
    word_t       data;
    logic [47:0] exp;
  } step_t;

  logic      clk = 1'b0;
  logic      reset;
  busReq_t   busReq;
  word_t     rdata;
  keyVec_t   keys;
  swVec_t    switches;
  ledVec_t   ledr;
  hexSegs_t  hex;
  logic      irq;
  irqCause_t irqCause;

  step_t  steps[$];
  string  testNames[$];
  int     errors      = 0;
  int     testErrors  = 0;
  int     testsRun    = 0;
  int     testsPassed = 0;
  int     budgetSum   = 0;
  int     cycleCount  = 0;
  int     timeoutLimit = 0;
  swVec_t swPattern;

  ioSubsystem #(
    .KEY_SAMPLE_PERIOD (KEY_SAMPLE),
    .SW_SAMPLE_PERIOD  (SW_SAMPLE),
    .MS_TICK_PERIOD    (TICK)
  ) ioSubsystem_inst (
    .clk      (clk),
    .reset    (reset),
    .busReq   (busReq),
    .rdata    (rdata),
    .keys     (keys),
    .switches (switches),
    .ledr     (ledr),
    .hex      (hex),
    .irq      (irq),
    .irqCause (irqCause)
  );

  always #5 clk = ~clk;

  // run limit from the summed step budgets
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
      $display("run stopped after %0d cycles with steps still pending", cycleCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic addStep(input action_t act, input word_t addr, input word_t data,
                         input logic [47:0] exp);
    step_t s;
    s.act  = act;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
    case (act)
      actWrite, actRead:     budgetSum += 2;
      actWait, actWaitCause: budgetSum += int'(data);
      default:               budgetSum += 1;
    endcase
  endtask

  task automatic countError();
    errors++;
    testErrors++;
  endtask

  task automatic busWrite(input word_t addr, input word_t data);
    @(negedge clk);
    busReq.addr  = addr;
    busReq.wdata = data;
    busReq.wrStb = 1'b1;
    busReq.rdStb = 1'b0;
    @(negedge clk);
    busReq.wrStb = 1'b0;
  endtask

  // rdata is combinational, sampled just after the strobe settles
  task automatic busRead(input word_t addr, output word_t got);
    @(negedge clk);
    busReq.addr  = addr;
    busReq.wdata = '0;
    busReq.rdStb = 1'b1;
    busReq.wrStb = 1'b0;
    #1;
    got = rdata;
    @(negedge clk);
    busReq.rdStb = 1'b0;
  endtask

  task automatic waitForCause(input irqCause_t cause, input int budget);
    int n;
    n = 0;
    while (irqCause !== cause && n < budget) begin
      @(negedge clk);
      n++;
    end
    assert (irqCause === cause) else begin
      $display("at %0t irqCause never reached %0d within %0d cycles", $time, cause, budget);
      countError();
    end
  endtask

  task automatic finishTest();
    testsRun++;
    if (testErrors == 0) begin
      testsPassed++;
      $display("test %0d %s: ok", testsRun, testNames[testsRun-1]);
    end else begin
      $display("test %0d %s: %0d error(s)", testsRun, testNames[testsRun-1], testErrors);
    end
    testErrors = 0;
  endtask

  task automatic runStep(input step_t s);
    word_t got;
    case (s.act)
      actWrite: busWrite(s.addr, s.data);
      actRead: begin
        busRead(s.addr, got);
        // unsigned difference, so a low value fails too
        assert (!$isunknown(got) && (got - s.exp[31:0]) <= s.data) else begin
          $display("ERROR %0t: read of 0x%08h gave 0x%08h, expected 0x%08h",
                   $time, s.addr, got, s.exp[31:0]);
          countError();
        end
      end
      actKeys: begin
        @(negedge clk);
        keys = keyVec_t'(s.data);
      end
      actSwitches: begin
        @(negedge clk);
        switches = swVec_t'(s.data);
      end
      actWait: repeat (s.data) @(negedge clk);
      actWaitCause: waitForCause(irqCause_t'(s.exp[1:0]), int'(s.data));
      actCheckIrq: begin
        @(negedge clk);
        assert ({irq, irqCause} === s.exp[2:0]) else begin
          $display("ERROR %0t: irq/irqCause %b/%0d, expected %b/%0d",
                   $time, irq, irqCause, s.exp[2], s.exp[1:0]);
          countError();
        end
      end
      actCheckLed: begin
        @(negedge clk);
        assert (ledr === s.exp[`LED_BITS-1:0]) else begin
          $display("ERROR %0t: ledr 0x%03h, expected 0x%03h", $time, ledr,
                   s.exp[`LED_BITS-1:0]);
          countError();
        end
      end
      actCheckHex: begin
        @(negedge clk);
        assert (hex === s.exp[41:0]) else begin
          $display("ERROR %0t: hex segments %h, expected %h", $time, hex, s.exp[41:0]);
          countError();
        end
      end
      default: finishTest();
    endcase
  endtask

  task automatic buildSteps();
    testNames.push_back("reset values");
    addStep(actCheckHex, '0, '0, 48'(SEGS_FEDEAD));
    addStep(actCheckLed, '0, '0, 48'h0);
    addStep(actCheckIrq, '0, '0, 48'h0);
    addStep(actRead, HEX_ADDR, 0, 48'h00FE_DEAD);
    addStep(actRead, LED_ADDR, 0, 48'h0);
    addStep(actRead, KEY_DATA, 0, 48'h0);
    addStep(actRead, KEY_CTRL, 0, 48'h0);
    addStep(actRead, SW_DATA, 0, 48'h0);
    addStep(actRead, SW_CTRL, 0, 48'h0);
    addStep(actRead, TMR_LIMIT, 0, 48'h0);
    addStep(actRead, TMR_CTRL, 0, 48'h0);
    addStep(actEnd, '0, '0, '0);

    // upper bits of the write data must be dropped
    testNames.push_back("display writes");
    addStep(actWrite, LED_ADDR, 32'hFFFF_F2A5, '0);
    addStep(actWrite, HEX_ADDR, 32'hFF12_3ABC, '0);
    addStep(actCheckLed, '0, '0, 48'h2A5);
    addStep(actCheckHex, '0, '0, 48'(SEGS_123ABC));
    addStep(actRead, LED_ADDR, 0, 48'h2A5);
    addStep(actRead, HEX_ADDR, 0, 48'h0012_3ABC);
    addStep(actRead, 32'hFFFF_F004, 0, 48'h0);
    addStep(actRead, 32'hFFFF_F040, 0, 48'h0);
    addStep(actEnd, '0, '0, '0);

    // pins low means pressed, 1010 presses keys 0 and 2
    testNames.push_back("key port");
    addStep(actWrite, KEY_CTRL, IE_BIT, '0);
    addStep(actRead, KEY_CTRL, 0, 48'h10);
    addStep(actKeys, '0, 32'b1010, '0);
    addStep(actWaitCause, '0, INPUT_BUDGET, 48'd2);
    addStep(actCheckIrq, '0, '0, 48'b110);
    addStep(actRead, KEY_DATA, 0, 48'h5);
    addStep(actCheckIrq, '0, '0, 48'h0);
    addStep(actKeys, '0, 32'b0110, '0);
    addStep(actWaitCause, '0, INPUT_BUDGET, 48'd2);
    // second change with ready still set
    addStep(actKeys, '0, 32'b1110, '0);
    addStep(actWait, '0, SETTLE_WAIT, '0);
    addStep(actRead, KEY_CTRL, 0, 48'h13);
    addStep(actRead, KEY_DATA, 0, 48'h1);
    addStep(actCheckIrq, '0, '0, 48'h0);
    addStep(actWrite, KEY_CTRL, 32'h0, '0);
    addStep(actRead, KEY_CTRL, 0, 48'h0);
    addStep(actEnd, '0, '0, '0);

    testNames.push_back("switch port");
    addStep(actWrite, SW_CTRL, IE_BIT, '0);
    addStep(actRead, SW_CTRL, 0, 48'h10);
    addStep(actSwitches, '0, 32'(swPattern), '0);
    addStep(actWaitCause, '0, INPUT_BUDGET, 48'd3);
    addStep(actCheckIrq, '0, '0, 48'b111);
    // timer pending on top, it wins
    addStep(actWrite, TMR_CTRL, IE_BIT, '0);
    addStep(actWrite, TMR_LIMIT, 32'd2, '0);
    addStep(actWaitCause, '0, TIMER_BUDGET, 48'd1);
    addStep(actCheckIrq, '0, '0, 48'b101);
    addStep(actRead, SW_DATA, 0, 48'(swPattern));
    addStep(actWrite, SW_CTRL, 32'h0, '0);
    addStep(actWrite, TMR_LIMIT, 32'h0, '0);
    addStep(actWrite, TMR_CTRL, 32'h0, '0);
    addStep(actCheckIrq, '0, '0, 48'h0);
    addStep(actEnd, '0, '0, '0);

    testNames.push_back("interval timer");
    addStep(actWrite, TMR_CTRL, IE_BIT, '0);
    addStep(actWrite, TMR_LIMIT, 32'd2, '0);
    addStep(actWaitCause, '0, TIMER_BUDGET, 48'd1);
    addStep(actCheckIrq, '0, '0, 48'b101);
    // stop further hits before overrun can set
    addStep(actWrite, TMR_LIMIT, 32'h0, '0);
    addStep(actRead, TMR_CTRL, 0, 48'h11);
    addStep(actWrite, TMR_CTRL, IE_BIT, '0);
    addStep(actCheckIrq, '0, '0, 48'h0);
    addStep(actRead, TMR_CTRL, 0, 48'h10);
    // free running, one tick may land before the read
    addStep(actWrite, TMR_COUNT, 32'h1234, '0);
    addStep(actRead, TMR_COUNT, 1, 48'h1234);
    addStep(actRead, TMR_LIMIT, 0, 48'h0);
    addStep(actWrite, TMR_CTRL, 32'h0, '0);
    addStep(actEnd, '0, '0, '0);
  endtask

  initial begin
    void'($urandom(11));
    reset          = 1'b1;
    busReq         = '0;
    keys           = '1;
    switches       = '0;
    // nonzero so the port sees a change
    swPattern      = swVec_t'($urandom());
    if (swPattern == '0)
      swPattern = 10'h155;
    buildSteps();
    timeoutLimit = RESET_CYCLES + budgetSum + MARGIN;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    foreach (steps[i])
      runStep(steps[i]);
    $display("%0d of %0d tests ok, %0d check errors, %0d assertion failures",
             testsPassed, testsRun, errors, ioSubsystem_inst.checkerInst.failCount);
    if (errors == 0 && ioSubsystem_inst.checkerInst.failCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/displayPorts.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module displayPorts
  import mmioPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  regAccess_t acc,
  output word_t      rd,
  output ledVec_t    ledr,
  output hexSegs_t   hex
);

  localparam int HEX_BITS = 4 * `HEX_DIGITS;

  ledVec_t             ledReg;
  logic [HEX_BITS-1:0] hexReg;

  // nibble to segments, segment on when low
  function automatic segs_t segDecode(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  // led and hex registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledReg <= '0;
      hexReg <= `HEX_RESET;
    end else if (acc.wrEn) begin
      if (acc.index == `DISP_LED_IDX)
        ledReg <= acc.wdata[`LED_BITS-1:0];
      else if (acc.index == `DISP_HEX_IDX)
        hexReg <= acc.wdata[HEX_BITS-1:0];
    end
  end

  // readback zero-extended
  always_comb begin
    case (acc.index)
      `DISP_HEX_IDX: rd = {{(`WORD_BITS-HEX_BITS){1'b0}}, hexReg};
      `DISP_LED_IDX: rd = {{(`WORD_BITS-`LED_BITS){1'b0}}, ledReg};
      default:       rd = '0;
    endcase
  end

  assign ledr = ledReg;

  // digit 5 shows the top nibble
  assign hex.digit5 = segDecode(hexReg[20 +: 4]);
  assign hex.digit4 = segDecode(hexReg[16 +: 4]);
  assign hex.digit3 = segDecode(hexReg[12 +: 4]);
  assign hex.digit2 = segDecode(hexReg[8 +: 4]);
  assign hex.digit1 = segDecode(hexReg[4 +: 4]);
  assign hex.digit0 = segDecode(hexReg[0 +: 4]);

endmodule

//--- verilog/inputPort.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module inputPort
  import mmioPkg::*;
#(
  parameter int WIDTH         = `KEY_BITS,
  parameter int SAMPLE_PERIOD = `KEY_SAMPLE_DEFAULT,
  parameter bit ACTIVE_LOW    = 1'b0
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] pins,
  input  regAccess_t       acc,
  output word_t            rd,
  output logic             irq
);

  localparam int CNT_BITS = $clog2(SAMPLE_PERIOD + 1);

  logic [CNT_BITS-1:0] sampleCnt;
  logic                sampleTick;
  logic [WIDTH-1:0]    pinLevel;
  logic [WIDTH-1:0]    sample;
  logic [WIDTH-1:0]    lastSample;
  logic [WIDTH-1:0]    data;
  logic                settled;
  logic                dataRead;
  logic                ctrlWrite;
  logic                ready;
  logic                overrun;
  logic                intEn;
  word_t               ctrlWord;

  // pressed reads as 1 for active-low pins
  assign pinLevel   = ACTIVE_LOW ? ~pins : pins;
  assign sampleTick = (sampleCnt == CNT_BITS'(SAMPLE_PERIOD - 1));
  // two matching samples that differ from what software saw
  assign settled    = sampleTick && (lastSample == sample) && (sample != data);
  assign dataRead   = acc.rdEn && (acc.index == 2'd0);
  assign ctrlWrite  = acc.wrEn && (acc.index == 2'd1);

  // sample period divider
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sampleCnt <= '0;
    end else if (sampleTick) begin
      sampleCnt <= '0;
    end else begin
      sampleCnt <= sampleCnt + 1'b1;
    end
  end

  // sample pipe and debounced data
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sample     <= '0;
      lastSample <= '0;
      data       <= '0;
    end else if (sampleTick) begin
      sample     <= pinLevel;
      lastSample <= sample;
      if (settled)
        data <= sample;
    end
  end

  // status bits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready   <= 1'b0;
      overrun <= 1'b0;
      intEn   <= 1'b0;
    end else begin
      // reading data acknowledges it
      if (dataRead)
        ready <= 1'b0;
      if (ctrlWrite) begin
        if (!acc.wdata[`CTRL_OVERRUN])
          overrun <= 1'b0;
        intEn <= acc.wdata[`CTRL_IE];
      end
      // new value while the old one is unread counts as overrun
      if (settled) begin
        ready <= 1'b1;
        if (ready)
          overrun <= 1'b1;
      end
    end
  end

  always_comb begin
    ctrlWord                = '0;
    ctrlWord[`CTRL_READY]   = ready;
    ctrlWord[`CTRL_OVERRUN] = overrun;
    ctrlWord[`CTRL_IE]      = intEn;
  end

  // register readback
  always_comb begin
    case (acc.index)
      2'd0:    rd = {{(`WORD_BITS-WIDTH){1'b0}}, data};
      2'd1:    rd = ctrlWord;
      default: rd = '0;
    endcase
  end

  assign irq = ready & intEn;

endmodule

//--- verilog/intervalTimer.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module intervalTimer
  import mmioPkg::*;
#(
  parameter int TICK_PERIOD = `MS_TICK_DEFAULT
) (
  input  logic       clk,
  input  logic       reset,
  input  regAccess_t acc,
  output word_t      rd,
  output logic       irq
);

  localparam int TICK_BITS = $clog2(TICK_PERIOD + 1);

  logic [TICK_BITS-1:0] divCnt;
  logic                 tick;
  word_t                count;
  word_t                limit;
  logic                 limitHit;
  logic                 cntWrite;
  logic                 limWrite;
  logic                 ctrlWrite;
  logic                 ready;
  logic                 overrun;
  logic                 intEn;
  word_t                ctrlWord;

  // one pulse per millisecond
  assign tick      = (divCnt == TICK_BITS'(TICK_PERIOD - 1));
  // a zero limit leaves the counter free running
  assign limitHit  = (limit != '0) && (count >= limit);
  assign cntWrite  = acc.wrEn && (acc.index == 2'd0);
  assign limWrite  = acc.wrEn && (acc.index == 2'd1);
  assign ctrlWrite = acc.wrEn && (acc.index == 2'd2);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      divCnt <= '0;
    end else if (tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // count and limit, bus writes take precedence
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
      limit <= '0;
    end else begin
      if (limitHit)
        count <= '0;
      else if (tick)
        count <= count + 1'b1;
      if (cntWrite)
        count <= acc.wdata;
      if (limWrite) begin
        limit <= acc.wdata;
        count <= '0;
      end
    end
  end

  // writing 0 to ready or overrun clears it, ie is loaded
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ready   <= 1'b0;
      overrun <= 1'b0;
      intEn   <= 1'b0;
    end else begin
      if (ctrlWrite) begin
        if (!acc.wdata[`CTRL_READY])
          ready <= 1'b0;
        if (!acc.wdata[`CTRL_OVERRUN])
          overrun <= 1'b0;
        intEn <= acc.wdata[`CTRL_IE];
      end
      if (limitHit) begin
        if (ready)
          overrun <= 1'b1;
        else
          ready <= 1'b1;
      end
    end
  end

  always_comb begin
    ctrlWord                = '0;
    ctrlWord[`CTRL_READY]   = ready;
    ctrlWord[`CTRL_OVERRUN] = overrun;
    ctrlWord[`CTRL_IE]      = intEn;
  end

  always_comb begin
    case (acc.index)
      2'd0:    rd = count;
      2'd1:    rd = limit;
      2'd2:    rd = ctrlWord;
      default: rd = '0;
    endcase
  end

  assign irq = ready & intEn;

endmodule

//--- verilog/ioController.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module ioController
  import mmioPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  busReq_t    busReq,
  output word_t      rdata,
  output regAccess_t keyAcc,
  output regAccess_t swAcc,
  output regAccess_t timerAcc,
  output regAccess_t dispAcc,
  input  word_t      keyRd,
  input  word_t      swRd,
  input  word_t      timerRd,
  input  word_t      dispRd,
  input  logic       keyIrq,
  input  logic       swIrq,
  input  logic       timerIrq,
  output logic       irq,
  output irqCause_t  irqCause
);

  word_t      addr;
  logic       isRead;
  logic       isWrite;
  logic       selHex;
  logic       selLed;
  logic       selKey;
  logic       selSw;
  logic       selTimer;
  logic [1:0] keyIdx;
  logic [1:0] swIdx;
  logic [1:0] timerIdx;
  logic [1:0] dispIdx;

  assign addr = busReq.addr;
  // a request with both strobes is a write
  assign isWrite = busReq.wrStb;
  assign isRead  = busReq.rdStb & ~busReq.wrStb;

  // address range match per peripheral
  assign selHex   = (addr == `ADDR_HEX);
  assign selLed   = (addr == `ADDR_LEDR);
  assign selKey   = (addr == `ADDR_KEY) || (addr == `ADDR_KEY + `CTRL_OFFSET);
  assign selSw    = (addr == `ADDR_SW) || (addr == `ADDR_SW + `CTRL_OFFSET);
  assign selTimer = (addr == `ADDR_TIMER) || (addr == `ADDR_TIMER + `LIMIT_OFFSET) ||
                    (addr == `ADDR_TIMER + `TCTRL_OFFSET);

  // word index inside each range
  assign keyIdx   = 2'((addr - `ADDR_KEY) >> 2);
  assign swIdx    = 2'((addr - `ADDR_SW) >> 2);
  assign timerIdx = 2'((addr - `ADDR_TIMER) >> 2);
  // led and hex share the display block, told apart by index
  assign dispIdx  = selLed ? `DISP_LED_IDX : `DISP_HEX_IDX;

  // enables reach only the addressed port
  assign keyAcc   = '{rdEn: isRead & selKey, wrEn: isWrite & selKey,
                      index: keyIdx, wdata: busReq.wdata};
  assign swAcc    = '{rdEn: isRead & selSw, wrEn: isWrite & selSw,
                      index: swIdx, wdata: busReq.wdata};
  assign timerAcc = '{rdEn: isRead & selTimer, wrEn: isWrite & selTimer,
                      index: timerIdx, wdata: busReq.wdata};
  assign dispAcc  = '{rdEn: isRead & (selHex | selLed), wrEn: isWrite & (selHex | selLed),
                      index: dispIdx, wdata: busReq.wdata};

  // read return, zero when idle or unmapped
  always_comb begin
    rdata = '0;
    if (isRead) begin
      if (selKey)
        rdata = keyRd;
      else if (selSw)
        rdata = swRd;
      else if (selTimer)
        rdata = timerRd;
      else if (selHex || selLed)
        rdata = dispRd;
    end
  end

  // single request line
  assign irq = timerIrq | keyIrq | swIrq;

  // cause code, timer wins over keys over switches
  always_comb begin
    if (timerIrq)
      irqCause = 2'd1;
    else if (keyIrq)
      irqCause = 2'd2;
    else if (swIrq)
      irqCause = 2'd3;
    else
      irqCause = 2'd0;
  end

endmodule

//--- verilog/ioSubsystem.sv
`include "mmio_defs.svh"
`timescale 1ns/1ps

module ioSubsystem
  import mmioPkg::*;
#(
  parameter int KEY_SAMPLE_PERIOD = `KEY_SAMPLE_DEFAULT,
  parameter int SW_SAMPLE_PERIOD  = `SW_SAMPLE_DEFAULT,
  parameter int MS_TICK_PERIOD    = `MS_TICK_DEFAULT
) (
  input  logic      clk,
  input  logic      reset,
  input  busReq_t   busReq,
  output word_t     rdata,
  input  keyVec_t   keys,
  input  swVec_t    switches,
  output ledVec_t   ledr,
  output hexSegs_t  hex,
  output logic      irq,
  output irqCause_t irqCause
);

  // per-peripheral access and return paths
  regAccess_t keyAcc;
  regAccess_t swAcc;
  regAccess_t timerAcc;
  regAccess_t dispAcc;
  word_t      keyRd;
  word_t      swRd;
  word_t      timerRd;
  word_t      dispRd;
  logic       keyIrq;
  logic       swIrq;
  logic       timerIrq;

  ioController ctrl (
    .clk      (clk),
    .reset    (reset),
    .busReq   (busReq),
    .rdata    (rdata),
    .keyAcc   (keyAcc),
    .swAcc    (swAcc),
    .timerAcc (timerAcc),
    .dispAcc  (dispAcc),
    .keyRd    (keyRd),
    .swRd     (swRd),
    .timerRd  (timerRd),
    .dispRd   (dispRd),
    .keyIrq   (keyIrq),
    .swIrq    (swIrq),
    .timerIrq (timerIrq),
    .irq      (irq),
    .irqCause (irqCause)
  );

  // buttons pull low when pressed
  inputPort #(
    .WIDTH         (`KEY_BITS),
    .SAMPLE_PERIOD (KEY_SAMPLE_PERIOD),
    .ACTIVE_LOW    (1'b1)
  ) keyPort (
    .clk   (clk),
    .reset (reset),
    .pins  (keys),
    .acc   (keyAcc),
    .rd    (keyRd),
    .irq   (keyIrq)
  );

  inputPort #(
    .WIDTH         (`SW_BITS),
    .SAMPLE_PERIOD (SW_SAMPLE_PERIOD),
    .ACTIVE_LOW    (1'b0)
  ) swPort (
    .clk   (clk),
    .reset (reset),
    .pins  (switches),
    .acc   (swAcc),
    .rd    (swRd),
    .irq   (swIrq)
  );

  intervalTimer #(
    .TICK_PERIOD (MS_TICK_PERIOD)
  ) timer (
    .clk   (clk),
    .reset (reset),
    .acc   (timerAcc),
    .rd    (timerRd),
    .irq   (timerIrq)
  );

  displayPorts display (
    .clk   (clk),
    .reset (reset),
    .acc   (dispAcc),
    .rd    (dispRd),
    .ledr  (ledr),
    .hex   (hex)
  );

endmodule

//--- verilog/mmioPkg.sv
`include "mmio_defs.svh"

package mmioPkg;

  // one bus data or address word
  typedef logic [`WORD_BITS-1:0] word_t;

  // button levels, active low at the pins
  typedef logic [`KEY_BITS-1:0] keyVec_t;

  // switch levels
  typedef logic [`SW_BITS-1:0] swVec_t;

  // led drive
  typedef logic [`LED_BITS-1:0] ledVec_t;

  // segments of one digit, active low
  typedef logic [`SEG_BITS-1:0] segs_t;

  // whole display, leftmost digit first
  typedef struct packed {
    segs_t digit5;
    segs_t digit4;
    segs_t digit3;
    segs_t digit2;
    segs_t digit1;
    segs_t digit0;
  } hexSegs_t;

  // one bus access as presented by the master
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  rdStb;
    logic  wrStb;
  } busReq_t;

  // access to a single peripheral after decode
  typedef struct packed {
    logic       rdEn;
    logic       wrEn;
    logic [1:0] index;
    word_t      wdata;
  } regAccess_t;

  // 0 none, 1 timer, 2 keys, 3 switches
  typedef logic [1:0] irqCause_t;

endpackage

//--- verilog/mmio_defs.svh
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// bus word width
`define WORD_BITS 32

// peripheral base addresses, one word each
`define ADDR_HEX   32'hFFFF_F000
`define ADDR_LEDR  32'hFFFF_F020
`define ADDR_KEY   32'hFFFF_F080
`define ADDR_SW    32'hFFFF_F090
`define ADDR_TIMER 32'hFFFF_F100

// register offsets within a port
`define CTRL_OFFSET  32'd4
`define LIMIT_OFFSET 32'd4
`define TCTRL_OFFSET 32'd8

// display register select as folded into the access index
`define DISP_HEX_IDX 2'b00
`define DISP_LED_IDX 2'b10

// pin and display widths
`define KEY_BITS   4
`define SW_BITS    10
`define LED_BITS   10
`define HEX_DIGITS 6
`define SEG_BITS   7

// display value out of reset
`define HEX_RESET 24'hFEDEAD

// control/status bit positions
`define CTRL_READY   0
`define CTRL_OVERRUN 1
`define CTRL_IE      4

// default periods in clk cycles
`define KEY_SAMPLE_DEFAULT 16
`define SW_SAMPLE_DEFAULT  4096
`define MS_TICK_DEFAULT    100000

`endif
